//--- source/bombPkg.sv
package bombPkg;

  // pixel coordinate widths for a 320x240 screen
  localparam int xWidth = 9;
  localparam int yWidth = 8;

  // top-left corner of the DEFUSED word
  localparam int bannerOriginX = 55;
  localparam int bannerOriginY = 96;

  // digit row placement
  localparam int digitOriginY = 40;
  localparam int minuteDigitX = 120;
  localparam int tensDigitX = 150;
  localparam int unitsDigitX = 170;

  // bounding box of one seven-segment digit
  localparam int digitWidth = 12;
  localparam int digitHeight = 21;
  // first row of the middle bar, g sits on this row and the next
  localparam int digitMidRow = (digitHeight - 3) / 2;

  // countdown start value, M:SS
  localparam int presetMinutes = 1;
  localparam int presetSeconds = 30;

  typedef enum logic [1:0] {
    idle     = 2'd0,
    armed    = 2'd1,
    defused  = 2'd2,
    exploded = 2'd3
  } gameState_t;

  typedef enum logic [1:0] {
    black = 2'd0,
    white = 2'd1,
    green = 2'd2,
    red   = 2'd3
  } pixelColor_t;

endpackage

//--- source/defusedBanner.sv
`timescale 1ns/10ps

module defusedBanner (
  input  logic [bombPkg::xWidth-1:0] x,
  input  logic [bombPkg::yWidth-1:0] y,
  output logic                       hit
);
  import bombPkg::*;

  // horizontal bar corners, relative to the banner origin
  localparam int horX [16] = '{
    4, 4, 33, 33, 33, 66, 66, 66, 101, 128, 128, 157, 157, 157, 190, 190
  };
  localparam int horY [16] = '{
    42, 0, 0, 21, 42, 0, 21, 42, 0, 21, 42, 0, 21, 42, 0, 42
  };

  // vertical bar corners
  localparam int verX [16] = '{
    0, 0, 52, 52, 62, 85, 95, 95, 118, 118, 147, 147, 176, 176, 186, 186
  };
  localparam int verY [16] = '{
    3, 24, 3, 24, 3, 24, 3, 24, 3, 24, 3, 24, 3, 24, 3, 24
  };

  // end caps closing the two D letters
  localparam int capX [2] = '{14, 200};
  // upper cap tapers at its bottom end, lower cap at its top end
  localparam int capUpperY = 6;
  localparam int capLowerY = 24;

  // bars are 20 long, caps 17
  localparam int barLength = 20;
  localparam int capLength = 17;

  // bar is 5 wide across; outer lanes lose 2 px per tapered end,
  // next lanes 1 px, the centre lane runs full length
  function automatic logic taperHit(
    input int along,
    input int across,
    input int len,
    input logic trimLow,
    input logic trimHigh
  );
    int trim;
    int lo;
    int hi;
    if (across == 2) begin
      trim = 0;
    end else if ((across == 1) || (across == 3)) begin
      trim = 1;
    end else begin
      trim = 2;
    end
    lo = trimLow ? trim : 0;
    hi = len - 1 - (trimHigh ? trim : 0);
    taperHit = (across >= 0) && (across <= 4) && (along >= lo) && (along <= hi);
  endfunction

  always_comb begin : bannerScan
    int relX;
    int relY;
    relX = int'(x) - bannerOriginX;
    relY = int'(y) - bannerOriginY;
    hit = 1'b0;

    // horizontal bars run along x, vertical ones along y
    for (int i = 0; i < 16; i++) begin
      if (taperHit(relX - horX[i], relY - horY[i], barLength, 1'b1, 1'b1)) begin
        hit = 1'b1;
      end
      if (taperHit(relY - verY[i], relX - verX[i], barLength, 1'b1, 1'b1)) begin
        hit = 1'b1;
      end
    end

    // square top edge, pointed bottom
    for (int k = 0; k < 2; k++) begin
      if (taperHit(relY - capUpperY, relX - capX[k], capLength, 1'b0, 1'b1)) begin
        hit = 1'b1;
      end
      // pointed top, square bottom
      if (taperHit(relY - capLowerY, relX - capX[k], capLength, 1'b1, 1'b0)) begin
        hit = 1'b1;
      end
    end
  end

endmodule

//--- source/countdownTimer.sv
`timescale 1ns/10ps

module countdownTimer (
  input  logic       clk,
  input  logic       rst,
  input  logic       tick,
  input  logic       timerRun,
  input  logic       timerLoad,
  output logic [3:0] minutes,
  output logic [3:0] secondsTens,
  output logic [3:0] secondsUnits,
  output logic       expired
);
  import bombPkg::*;

  // BCD countdown M:SS
  always_ff @(posedge clk) begin
    if (rst || timerLoad) begin
      minutes <= 4'(presetMinutes);
      secondsTens <= 4'(presetSeconds / 10);
      secondsUnits <= 4'(presetSeconds % 10);
    end else if (timerRun && tick && !expired) begin
      if (secondsUnits != 4'd0) begin
        secondsUnits <= secondsUnits - 4'd1;
      end else begin
        // borrow from the tens digit
        secondsUnits <= 4'd9;
        if (secondsTens != 4'd0) begin
          secondsTens <= secondsTens - 4'd1;
        end else begin
          // borrow a minute, seconds wrap to 59
          secondsTens <= 4'd5;
          minutes <= minutes - 4'd1;
        end
      end
    end
  end

  // holds at 0:00 since the decrement is blocked
  assign expired = (minutes == 4'd0) && (secondsTens == 4'd0) && (secondsUnits == 4'd0);

  // digits stay valid BCD across every borrow
  tensInRange: assert property (@(posedge clk) disable iff (rst) secondsTens < 4'd6);
  unitsInRange: assert property (@(posedge clk) disable iff (rst) secondsUnits < 4'd10);

endmodule

//--- source/digitGlyph.sv
`timescale 1ns/10ps

module digitGlyph #(
  parameter int originX = 0
) (
  input  logic [bombPkg::xWidth-1:0] x,
  input  logic [bombPkg::yWidth-1:0] y,
  input  logic [3:0]                 value,
  output logic                       hit
);
  import bombPkg::*;

  // lit segments, bit 6 is a down to bit 0 is g
  logic [6:0] segs;
  logic [xWidth-1:0] relX;
  logic [yWidth-1:0] relY;
  logic inBox;
  logic rowTop;
  logic rowUpper;
  logic rowMid;
  logic rowLower;
  logic rowBot;
  logic colLeft;
  logic colInner;
  logic colRight;

  // usual seven-segment pattern, blank above 9
  always_comb begin
    case (value)
      4'd0: segs = 7'b1111110;
      4'd1: segs = 7'b0110000;
      4'd2: segs = 7'b1101101;
      4'd3: segs = 7'b1111001;
      4'd4: segs = 7'b0110011;
      4'd5: segs = 7'b1011011;
      4'd6: segs = 7'b1011111;
      4'd7: segs = 7'b1110000;
      4'd8: segs = 7'b1111111;
      4'd9: segs = 7'b1111011;
      default: segs = 7'b0000000;
    endcase
  end

  // position inside the digit box
  assign relX = x - xWidth'(originX);
  assign relY = y - yWidth'(digitOriginY);
  assign inBox = (x >= xWidth'(originX)) && (relX < xWidth'(digitWidth))
              && (y >= yWidth'(digitOriginY)) && (relY < yWidth'(digitHeight));

  // 2 px thick horizontal bands
  assign rowTop = relY < yWidth'(2);
  assign rowMid = (relY == yWidth'(digitMidRow)) || (relY == yWidth'(digitMidRow + 1));
  assign rowBot = relY >= yWidth'(digitHeight - 2);
  // vertical segment spans between the bands
  assign rowUpper = (relY >= yWidth'(2)) && (relY < yWidth'(digitMidRow));
  assign rowLower = (relY >= yWidth'(digitMidRow + 2)) && (relY < yWidth'(digitHeight - 2));

  // columns
  assign colLeft = relX < xWidth'(2);
  assign colRight = relX >= xWidth'(digitWidth - 2);
  assign colInner = !colLeft && !colRight;

  assign hit = inBox && (
      (segs[6] && rowTop && colInner)
    || (segs[5] && rowUpper && colRight)
    || (segs[4] && rowLower && colRight)
    || (segs[3] && rowBot && colInner)
    || (segs[2] && rowLower && colLeft)
    || (segs[1] && rowUpper && colLeft)
    || (segs[0] && rowMid && colInner));

endmodule

//--- source/bombController.sv
`timescale 1ns/10ps

module bombController (
  input  logic                clk,
  input  logic                rst,
  input  logic                start,
  input  logic                defuse,
  input  logic                expired,
  output bombPkg::gameState_t state,
  output logic                timerRun,
  output logic                timerLoad
);
  import bombPkg::*;

  gameState_t nextState;

  always_comb begin
    nextState = state;
    case (state)
      idle: begin
        if (start) begin
          nextState = armed;
        end
      end
      armed: begin
        // defuse wins over a same-cycle expiry
        if (defuse) begin
          nextState = defused;
        end else if (expired) begin
          nextState = exploded;
        end
      end
      // defused and exploded are terminal until reset
      default: begin
        nextState = state;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= idle;
    end else begin
      state <= nextState;
    end
  end

  // countdown only moves while armed
  assign timerRun = (state == armed);
  // preset reload lands on the same edge as the move to armed
  assign timerLoad = (state == idle) && start;

  // terminal states only leave through reset
  endStateHeld: assert property (@(posedge clk) disable iff (rst)
    (state inside {defused, exploded}) |=> $stable(state));

endmodule

//--- source/pixelCompositor.sv
`timescale 1ns/10ps

module pixelCompositor (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 bannerHit,
  input  logic                 digitHit0,
  input  logic                 digitHit1,
  input  logic                 digitHit2,
  input  bombPkg::gameState_t  state,
  output bombPkg::pixelColor_t pixelColor
);
  import bombPkg::*;

  pixelColor_t nextColor;
  logic anyDigit;

  assign anyDigit = digitHit0 || digitHit1 || digitHit2;

  // banner over digits, digits over background
  always_comb begin
    nextColor = black;
    if ((state == defused) && bannerHit) begin
      nextColor = green;
    end else if (anyDigit) begin
      case (state)
        defused: nextColor = green;
        exploded: nextColor = red;
        default: nextColor = white;
      endcase
    end
  end

  // one cycle behind the coordinate
  always_ff @(posedge clk) begin
    if (rst) begin
      pixelColor <= black;
    end else begin
      pixelColor <= nextColor;
    end
  end

  // green pixels come only from a defused state one cycle earlier
  greenOnlyDefused: assert property (@(posedge clk) disable iff (rst)
    (pixelColor == green) |-> ($past(state) == defused));

endmodule

//--- source/bombDisplay.sv
`timescale 1ns/10ps

module bombDisplay (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [bombPkg::xWidth-1:0] x,
  input  logic [bombPkg::yWidth-1:0] y,
  input  logic                      start,
  input  logic                      defuse,
  input  logic                      tick,
  output bombPkg::pixelColor_t      pixelColor,
  output bombPkg::gameState_t       state
);
  import bombPkg::*;

  // control path
  logic timerRun;
  logic timerLoad;
  logic expired;
  logic [3:0] minutes;
  logic [3:0] secondsTens;
  logic [3:0] secondsUnits;

  // pixel path
  logic bannerHit;
  logic digitHit0;
  logic digitHit1;
  logic digitHit2;

  bombController controller (
    .clk(clk),
    .rst(rst),
    .start(start),
    .defuse(defuse),
    .expired(expired),
    .state(state),
    .timerRun(timerRun),
    .timerLoad(timerLoad)
  );

  countdownTimer timer (
    .clk(clk),
    .rst(rst),
    .tick(tick),
    .timerRun(timerRun),
    .timerLoad(timerLoad),
    .minutes(minutes),
    .secondsTens(secondsTens),
    .secondsUnits(secondsUnits),
    .expired(expired)
  );

  defusedBanner banner (.x(x), .y(y), .hit(bannerHit));

  // M:SS digits left to right
  digitGlyph #(.originX(minuteDigitX)) minuteDigit (
    .x(x), .y(y), .value(minutes), .hit(digitHit0)
  );
  digitGlyph #(.originX(tensDigitX)) tensDigit (
    .x(x), .y(y), .value(secondsTens), .hit(digitHit1)
  );
  digitGlyph #(.originX(unitsDigitX)) unitsDigit (
    .x(x), .y(y), .value(secondsUnits), .hit(digitHit2)
  );

  pixelCompositor compositor (
    .clk(clk),
    .rst(rst),
    .bannerHit(bannerHit),
    .digitHit0(digitHit0),
    .digitHit1(digitHit1),
    .digitHit2(digitHit2),
    .state(state),
    .pixelColor(pixelColor)
  );

endmodule

//--- verification/bombDisplayTb.sv
`timescale 1ns/10ps

module bombDisplayTb;
  import bombPkg::*;

  logic clk;
  logic rst;
  logic [xWidth-1:0] x;
  logic [yWidth-1:0] y;
  logic start;
  logic defuse;
  logic tick;
  pixelColor_t pixelColor;
  gameState_t state;

  // parsed test lines, six numbers per line in fields
  string names[$];
  string cmds[$];
  int fields[$];

  int seed = 32'hbb0257ef;
  int cycles = 0;
  int cycleLimit = 200;

  bombDisplay dut (
    .clk(clk),
    .rst(rst),
    .x(x),
    .y(y),
    .start(start),
    .defuse(defuse),
    .tick(tick),
    .pixelColor(pixelColor),
    .state(state)
  );

  // 100 ns period
  always #50 clk = ~clk;

  // watchdog, limit set once the data file is read
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > cycleLimit) begin
      $display("Regression failed");
      $fatal(1, "timeout, the tests did not finish within %0d cycles", cycleLimit);
    end
  end

  task automatic checkColor(input string name, input pixelColor_t expected,
                            input pixelColor_t actual);
    if (actual !== expected) begin
      $display("Mismatch %s: expected %s, actual %s", name, expected.name(), actual.name());
      $display("Regression failed");
      $fatal(1, "wrong pixel colour");
    end
  endtask

  task automatic checkState(input string name, input gameState_t expected,
                            input gameState_t actual);
    if (actual !== expected) begin
      $display("Mismatch %s: expected %s, actual %s", name, expected.name(), actual.name());
      $display("Regression failed");
      $fatal(1, "wrong game state");
    end
  endtask

  task automatic readTests();
    int fd;
    int n;
    string line;
    string name;
    string cmd;
    int v[6];
    fd = $fopen("verification/bombDisplay_testdata.txt", "r");
    if (fd == 0) begin
      $display("Regression failed");
      $fatal(1, "could not open verification/bombDisplay_testdata.txt");
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      // comment lines start with #
      if ((n > 0) && (line.substr(0, 0) != "#")) begin
        n = $sscanf(line, "%s %s %d %d %d %d %d %d", name, cmd,
                    v[0], v[1], v[2], v[3], v[4], v[5]);
        if (n == 8) begin
          names.push_back(name);
          cmds.push_back(cmd);
          foreach (v[k]) begin
            fields.push_back(v[k]);
          end
        end
      end
    end
    $fclose(fd);
  endtask

  // colour of this coordinate is registered on the next rising edge
  task automatic showPixel(input int px, input int py);
    x = xWidth'(px);
    y = yWidth'(py);
    @(negedge clk);
  endtask

  task automatic pulseStart();
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic pulseDefuse();
    defuse = 1'b1;
    @(negedge clk);
    defuse = 1'b0;
  endtask

  // one tick per cycle, then a cycle for the state to follow expiry
  task automatic runTicks(input int count);
    tick = 1'b1;
    repeat (count) @(negedge clk);
    tick = 1'b0;
    @(negedge clk);
  endtask

  task automatic applyReset();
    rst = 1'b1;
    repeat (2) @(negedge clk);
    rst = 1'b0;
  endtask

  // random coordinates inside a region with nothing drawn
  task automatic scanEmpty(input string name, input int x0, input int y0, input int w,
                           input int h, input pixelColor_t expected);
    int px;
    int py;
    for (int k = 0; k < 64; k++) begin
      px = x0 + int'($unsigned($random(seed)) % w);
      py = y0 + int'($unsigned($random(seed)) % h);
      showPixel(px, py);
      checkColor(name, expected, pixelColor);
    end
  endtask

  initial begin : mainFlow
    pixelColor_t expColor;
    gameState_t expState;
    int base;
    clk = 1'b0;
    rst = 1'b1;
    x = '0;
    y = '0;
    start = 1'b0;
    defuse = 1'b0;
    tick = 1'b0;
    readTests();
    cycleLimit = names.size() * 100 + 200;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    foreach (names[i]) begin
      base = 6 * i;
      expState = gameState_t'(2'(fields[base + 4]));
      expColor = pixelColor_t'(2'(fields[base + 5]));
      case (cmds[i])
        "P": begin
          showPixel(fields[base], fields[base + 1]);
          checkColor(names[i], expColor, pixelColor);
        end
        "S": pulseStart();
        "D": pulseDefuse();
        "T": runTicks(fields[base]);
        "R": begin
          applyReset();
          checkColor(names[i], expColor, pixelColor);
        end
        "E": scanEmpty(names[i], fields[base], fields[base + 1], fields[base + 2],
                       fields[base + 3], expColor);
        default: begin
          $display("Regression failed");
          $fatal(1, "unknown command %s in test %s", cmds[i], names[i]);
        end
      endcase
      checkState(names[i], expState, state);
    end
    $display("Regression passed");
    $finish;
  end

endmodule

//--- verification/bombDisplay_testdata.txt
# name cmd a b c d state color; P pixel a=x b=y, S start, D defuse, T a=ticks, R reset, E scan
# E region a=x0 b=y0 c=width d=height; state 0 idle 1 armed 2 defused 3 exploded; color 0 black 1 white 2 green 3 red
rstMinB P 130 45 0 0 0 1
rstTensA P 155 40 0 0 0 1
rstUnitsE P 170 55 0 0 0 1
rstBanner P 69 98 0 0 0 0
arm S 0 0 0 0 1 0
tick3 T 3 0 0 0 1 0
unitsMidGap P 181 50 0 0 1 0
tensTwoC P 161 55 0 0 1 0
tensTwoE P 150 55 0 0 1 1
tensCorner P 151 60 0 0 1 0
burst0 P 169 41 0 0 1 0
burst1 P 172 41 0 0 1 1
burst2 P 179 41 0 0 1 1
burst3 P 180 41 0 0 1 0
burst4 P 181 52 0 0 1 1
defuse D 0 0 0 0 2 0
bannerBar P 69 98 0 0 2 2
bannerTaper P 59 96 0 0 2 0
capSquare P 69 102 0 0 2 2
capPoint P 69 118 0 0 2 0
defusedDigit P 172 41 0 0 2 2
background E 0 160 320 80 2 0
freshReset R 0 0 0 0 0 0
rearm S 0 0 0 0 1 0
tick90 T 90 0 0 0 3 0
zeroMinF P 120 45 0 0 3 3
zeroMinG P 125 49 0 0 3 0
lateDefuse D 0 0 0 0 3 0
lateTick T 1 0 0 0 3 0
holdUnitsD P 175 60 0 0 3 3

//--- files.f
source/bombPkg.sv
source/defusedBanner.sv
source/countdownTimer.sv
source/digitGlyph.sv
source/bombController.sv
source/pixelCompositor.sv
source/bombDisplay.sv
verification/bombDisplayTb.sv

//--- run.sh
#!/bin/sh
# compile the DUT and testbench with Verilator, then run the regression
set -e
cd "$(dirname "$0")"
verilator --binary --assert --timescale 1ns/10ps -f files.f \
  --top-module bombDisplayTb -o bombDisplaySim
./obj_dir/bombDisplaySim
